// ==== sim.f ====
+incdir+.
axi_pkg.sv
host_mem_pkg.sv
cmd_fifo.sv
host_mem_array.sv
host_mem_wr.sv
host_mem_rd.sv
host_mem_top.sv
tb_host_mem_chk.sv
tb_host_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the host memory testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_host_mem \
   --Mdir obj_dir -o tb_host_mem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_host_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qF "** FAIL **" sim.log; then
   exit 1
fi
exit 0

// ==== tb_host_mem.sv ====
// host memory testbench
// drives the five channels, keeps a reference memory and prints the totals
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module tb_host_mem
   import axi_pkg::*;
   import host_mem_pkg::*;
();

   localparam int timeout_cycles = 2000;

   logic                  clk_out = 1'b0;
   logic                  sync_rst_n;
   logic                  awvalid;
   logic                  awready;
   axi_ax_t               aw;
   logic                  wvalid;
   logic                  wready;
   axi_w_t                w;
   logic                  bvalid;
   logic                  bready;
   axi_b_t                b;
   logic                  arvalid;
   logic                  arready;
   axi_ax_t               ar;
   logic                  rvalid;
   logic                  rready;
   axi_r_t                r;
   int                    seed = 54;
   int                    tb_errors = 0;
   int                    chk_errors;
   logic                  gap_en = 1'b0;
   logic [31:0]           gap_rnd;
   logic [`HM_DATA_W-1:0] ref_mem [`HM_DEPTH];
   logic [`HM_STRB_W-1:0] ref_known [`HM_DEPTH];   // bytes written so far

   always #5 clk_out = ~clk_out;

   host_mem_top uut (
      .clk_out(clk_out), .sync_rst_n(sync_rst_n),
      .awvalid_i(awvalid), .awready_o(awready), .aw_i(aw),
      .wvalid_i(wvalid), .wready_o(wready), .w_i(w),
      .bvalid_o(bvalid), .bready_i(bready), .b_o(b),
      .arvalid_i(arvalid), .arready_o(arready), .ar_i(ar),
      .rvalid_o(rvalid), .rready_i(rready), .r_o(r)
   );

   tb_host_mem_chk u_chk (
      .clk_out(clk_out), .sync_rst_n(sync_rst_n),
      .bvalid_i(bvalid), .bready_i(bready), .b_i(b),
      .rvalid_i(rvalid), .rready_i(rready), .r_i(r),
      .err_cnt_o(chk_errors)
   );

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   // strobed bytes replace the old ones in issue order
   function automatic logic [`HM_DATA_W-1:0] expect_word(input logic [`HM_DATA_W-1:0] old_word,
                                                         input logic [`HM_DATA_W-1:0] data,
                                                         input logic [`HM_STRB_W-1:0] strb);
      logic [`HM_DATA_W-1:0] word;
      word = old_word;
      for (int i = 0; i < `HM_STRB_W; i++) begin
         if (strb[i]) word[i*8 +: 8] = data[i*8 +: 8];
      end
      return word;
   endfunction

   function automatic logic [`HM_DATA_W-1:0] byte_mask(input logic [`HM_STRB_W-1:0] known);
      logic [`HM_DATA_W-1:0] mask;
      for (int i = 0; i < `HM_STRB_W; i++) mask[i*8 +: 8] = {8{known[i]}};
      return mask;
   endfunction

   // upper address bits and byte offset are random and ignored by the DUT
   function automatic axi_ax_t make_cmd(input logic [`HM_ID_W-1:0] id, input mem_idx_t idx,
                                        input logic [`HM_LEN_W-1:0] len);
      logic [31:0] rnd;
      axi_ax_t     cmd;
      rnd      = next_rand();
      cmd.id   = id;
      cmd.addr = {rnd[4:0], idx, rnd[7:5]};
      cmd.len  = len;
      return cmd;
   endfunction

   task automatic flag_error(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      tb_errors++;
   endtask

   task automatic fail_timeout(input string what);
      $display("timed out after %0d cycles waiting for %s", timeout_cycles, what);
      $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors + 1);
      $display("** FAIL **");
      $finish;
   endtask

   // --------------------
   // channel drivers called on a falling edge
   task automatic send_aw(input axi_ax_t cmd);
      int n;
      n       = 0;
      aw      = cmd;
      awvalid = 1'b1;
      while (!awready && n < timeout_cycles) begin
         @(negedge clk_out);
         n++;
      end
      if (!awready) fail_timeout("awready");
      u_chk.expect_b(cmd.id);
      @(negedge clk_out);   // taken on the edge between
      awvalid = 1'b0;
   endtask

   task automatic send_w_burst(input mem_idx_t start, input int len,
                               input logic [`HM_STRB_W-1:0] strb, input bit rand_strb);
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      logic [31:0] r_s;
      mem_idx_t    idx;
      int          n;
      int          k;
      idx = start;
      for (k = 0; k <= len; k++) begin
         r_hi   = next_rand();
         r_lo   = next_rand();
         r_s    = next_rand();
         w.data = {r_hi, r_lo};
         w.strb = rand_strb ? r_s[7:0] : strb;
         w.last = (k == len);
         wvalid = 1'b1;
         n      = 0;
         while (!wready && n < timeout_cycles) begin
            @(negedge clk_out);
            n++;
         end
         if (!wready) fail_timeout("wready");
         ref_mem[idx]   = expect_word(ref_mem[idx], w.data, w.strb);
         ref_known[idx] = ref_known[idx] | w.strb;
         idx            = idx + 1'b1;
         @(negedge clk_out);
      end
      wvalid = 1'b0;
   endtask

   task automatic send_ar(input axi_ax_t cmd);
      mem_idx_t idx;
      int       n;
      int       k;
      idx = cmd.addr[3 +: `HM_IDX_W];
      u_chk.expect_r(cmd.id, cmd.len);
      for (k = 0; k <= int'(cmd.len); k++) begin
         u_chk.expect_beat(ref_mem[idx], byte_mask(ref_known[idx]));
         idx = idx + 1'b1;
      end
      n       = 0;
      ar      = cmd;
      arvalid = 1'b1;
      while (!arready && n < timeout_cycles) begin
         @(negedge clk_out);
         n++;
      end
      if (!arready) fail_timeout("arready");
      @(negedge clk_out);
      arvalid = 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (u_chk.pending() != 0 && n < timeout_cycles) begin
         @(negedge clk_out);
         n++;
      end
      if (u_chk.pending() != 0) fail_timeout("outstanding write responses and read beats");
   endtask

   // random ready gaps with ready high three cycles in four
   always @(negedge clk_out) begin
      if (gap_en) begin
         gap_rnd = next_rand();
         rready  = (gap_rnd[1:0] != 2'b00);
         bready  = (gap_rnd[3:2] != 2'b00);
      end
   end

   initial begin
      axi_ax_t               wcmd;
      axi_ax_t               rcmd;
      logic [31:0]           rnd;
      mem_idx_t              widx;
      mem_idx_t              ridx;
      logic [`HM_STRB_W-1:0] strbs [4];
      int                    k;
      strbs      = '{8'hff, 8'h0f, 8'hc0, 8'h3c};
      sync_rst_n = 1'b0;
      awvalid    = 1'b0;
      aw         = '0;
      wvalid     = 1'b0;
      w          = '0;
      bready     = 1'b1;
      arvalid    = 1'b0;
      ar         = '0;
      rready     = 1'b1;
      foreach (ref_known[i]) ref_known[i] = '0;
      repeat (8) @(posedge clk_out);
      @(negedge clk_out);
      sync_rst_n = 1'b1;
      @(negedge clk_out);

      if (bvalid !== 1'b0 || rvalid !== 1'b0 || wready !== 1'b0)
         flag_error("bvalid, rvalid or wready high after reset");
      if (awready !== 1'b1 || arready !== 1'b1)
         flag_error("awready or arready low after reset");

      // single beat then read back
      send_aw(make_cmd(5'd3, 8'd10, 8'd0));
      send_w_burst(8'd10, 0, 8'hff, 1'b0);
      wait_idle();
      send_ar(make_cmd(5'd7, 8'd10, 8'd0));
      wait_idle();

      // partial writes to one word
      for (k = 0; k < 4; k++) begin
         send_aw(make_cmd(`HM_ID_W'(k + 8), 8'd20, 8'd0));
         send_w_burst(8'd20, 0, strbs[k], 1'b0);
         wait_idle();
      end
      send_ar(make_cmd(5'd12, 8'd20, 8'd0));
      wait_idle();

      // 8 beat bursts
      send_aw(make_cmd(5'd13, 8'd40, 8'd7));
      send_w_burst(8'd40, 7, 8'hff, 1'b0);
      wait_idle();
      send_ar(make_cmd(5'd14, 8'd40, 8'd7));
      wait_idle();

      // --------------------
      // commands pile up while responses are held back
      bready = 1'b0;
      send_aw(make_cmd(5'd1, 8'd60, 8'd1));
      send_w_burst(8'd60, 1, 8'hff, 1'b0);
      for (k = 0; k < `HM_CMD_DEPTH; k++) begin
         send_aw(make_cmd(`HM_ID_W'(k + 16), mem_idx_t'(64 + 2 * k), 8'd1));
      end
      if (awready !== 1'b0) flag_error("awready high with a full write command queue");
      bready = 1'b1;
      for (k = 0; k < `HM_CMD_DEPTH; k++) begin
         send_w_burst(mem_idx_t'(64 + 2 * k), 1, 8'hff, 1'b0);
      end
      wait_idle();

      // --------------------
      // whole memory first then mixed traffic in opposite halves
      send_aw(make_cmd(5'd30, 8'd0, 8'd255));
      send_w_burst(8'd0, 255, 8'hff, 1'b0);
      wait_idle();
      gap_en = 1'b1;
      for (k = 0; k < 40; k++) begin
         rnd  = next_rand();
         widx = mem_idx_t'((k % 2) * 128 + int'(rnd[7:0]) % 121);
         ridx = mem_idx_t'((1 - k % 2) * 128 + int'(rnd[15:8]) % 121);
         wcmd = make_cmd(rnd[20:16], widx, {5'd0, rnd[23:21]});
         rcmd = make_cmd(rnd[28:24], ridx, {5'd0, rnd[31:29]});
         fork
            begin
               send_aw(wcmd);
               send_w_burst(widx, int'(wcmd.len), 8'h00, 1'b1);
            end
            send_ar(rcmd);
         join
         wait_idle();
      end
      gap_en = 1'b0;
      @(negedge clk_out);
      rready = 1'b1;
      bready = 1'b1;
      repeat (4) @(negedge clk_out);

      $display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== tb_host_mem_chk.sv ====
// host memory checker
// compares write responses and read beats with the queued expectations
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module tb_host_mem_chk
   import axi_pkg::*;
(
   input  logic   clk_out,
   input  logic   sync_rst_n,
   input  logic   bvalid_i,
   input  logic   bready_i,
   input  axi_b_t b_i,
   input  logic   rvalid_i,
   input  logic   rready_i,
   input  axi_r_t r_i,
   output int     err_cnt_o
);

   logic [`HM_ID_W-1:0]   b_id_q [$];
   logic [`HM_ID_W-1:0]   r_id_q [$];
   logic [`HM_LEN_W-1:0]  r_len_q [$];
   logic [`HM_DATA_W-1:0] beat_data_q [$];
   logic [`HM_DATA_W-1:0] beat_mask_q [$];   // known bytes only
   int                    beat_num = 0;
   int                    errors = 0;

   assign err_cnt_o = errors;

   task automatic expect_b(input logic [`HM_ID_W-1:0] id);
      b_id_q.push_back(id);
   endtask

   task automatic expect_r(input logic [`HM_ID_W-1:0] id, input logic [`HM_LEN_W-1:0] len);
      r_id_q.push_back(id);
      r_len_q.push_back(len);
   endtask

   task automatic expect_beat(input logic [`HM_DATA_W-1:0] data,
                              input logic [`HM_DATA_W-1:0] mask);
      beat_data_q.push_back(data);
      beat_mask_q.push_back(mask);
   endtask

   function automatic int pending();
      return b_id_q.size() + r_id_q.size();
   endfunction

   task automatic report_mismatch(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      errors++;
   endtask

   // --------------------
   // write response
   task automatic check_b();
      logic [`HM_ID_W-1:0] id;
      if (b_id_q.size() == 0) begin
         $display("write response at %0t with no write command outstanding", $time);
         errors++;
      end else begin
         id = b_id_q.pop_front();
         if (b_i.id !== id) report_mismatch($sformatf("bid %0d, expected %0d", b_i.id, id));
         if (b_i.resp !== resp_okay) report_mismatch($sformatf("bresp %0d", b_i.resp));
      end
   endtask

   // --------------------
   // read beat
   task automatic check_r();
      logic [`HM_DATA_W-1:0] exp_data;
      logic [`HM_DATA_W-1:0] mask;
      logic                  exp_last;
      if (r_id_q.size() == 0 || beat_data_q.size() == 0) begin
         $display("read beat at %0t with no read command outstanding", $time);
         errors++;
      end else begin
         exp_data = beat_data_q.pop_front();
         mask     = beat_mask_q.pop_front();
         exp_last = (beat_num == int'(r_len_q[0]));
         if (r_i.id !== r_id_q[0])
            report_mismatch($sformatf("rid %0d, expected %0d", r_i.id, r_id_q[0]));
         if (r_i.resp !== resp_okay) report_mismatch($sformatf("rresp %0d", r_i.resp));
         if (((r_i.data ^ exp_data) & mask) !== '0)
            report_mismatch($sformatf("rdata %h, expected %h mask %h, beat %0d",
                                      r_i.data, exp_data, mask, beat_num));
         if (r_i.last !== exp_last)
            report_mismatch($sformatf("rlast %b on beat %0d of len %0d",
                                      r_i.last, beat_num, r_len_q[0]));
         if (exp_last) begin
            void'(r_id_q.pop_front());
            void'(r_len_q.pop_front());
            beat_num = 0;
         end else begin
            beat_num++;
         end
      end
   endtask

   always @(posedge clk_out) begin
      if (sync_rst_n && bvalid_i && bready_i) check_b();
      if (sync_rst_n && rvalid_i && rready_i) check_r();   // one beat per edge
   end

endmodule

// ==== host_mem_top.sv ====
// host memory slave top
// command queues, write and read engines around the shared memory
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module host_mem_top
   import axi_pkg::*;
   import host_mem_pkg::*;
(
   input  logic    clk_out,
   input  logic    sync_rst_n,
   input  logic    awvalid_i,
   output logic    awready_o,
   input  axi_ax_t aw_i,
   input  logic    wvalid_i,
   output logic    wready_o,
   input  axi_w_t  w_i,
   output logic    bvalid_o,
   input  logic    bready_i,
   output axi_b_t  b_o,
   input  logic    arvalid_i,
   output logic    arready_o,
   input  axi_ax_t ar_i,
   output logic    rvalid_o,
   input  logic    rready_i,
   output axi_r_t  r_o
);

   axi_ax_t               aw_head;
   logic                  aw_head_valid;
   logic                  aw_head_ready;
   axi_ax_t               ar_head;
   logic                  ar_head_valid;
   logic                  ar_head_ready;
   mem_wr_t               mem_wr;
   logic                  rd_en;
   mem_idx_t              rd_idx;
   logic [`HM_DATA_W-1:0] rd_data;

   // --------------------
   // write path
   cmd_fifo #(.payload_t(axi_ax_t)) u_aw_fifo (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .in_valid_i  (awvalid_i),
      .in_ready_o  (awready_o),
      .in_data_i   (aw_i),
      .out_valid_o (aw_head_valid),
      .out_ready_i (aw_head_ready),
      .out_data_o  (aw_head)
   );

   host_mem_wr u_wr (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .cmd_valid_i (aw_head_valid),
      .cmd_ready_o (aw_head_ready),
      .cmd_i       (aw_head),
      .wvalid_i    (wvalid_i),
      .wready_o    (wready_o),
      .w_i         (w_i),
      .bvalid_o    (bvalid_o),
      .bready_i    (bready_i),
      .b_o         (b_o),
      .mem_wr_o    (mem_wr)
   );

   // --------------------
   // read path
   cmd_fifo #(.payload_t(axi_ax_t)) u_ar_fifo (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .in_valid_i  (arvalid_i),
      .in_ready_o  (arready_o),
      .in_data_i   (ar_i),
      .out_valid_o (ar_head_valid),
      .out_ready_i (ar_head_ready),
      .out_data_o  (ar_head)
   );

   host_mem_rd u_rd (
      .clk_out     (clk_out),
      .sync_rst_n  (sync_rst_n),
      .cmd_valid_i (ar_head_valid),
      .cmd_ready_o (ar_head_ready),
      .cmd_i       (ar_head),
      .rvalid_o    (rvalid_o),
      .rready_i    (rready_i),
      .r_o         (r_o),
      .rd_en_o     (rd_en),
      .rd_idx_o    (rd_idx),
      .rd_data_i   (rd_data)
   );

   host_mem_array u_mem (
      .clk_out   (clk_out),
      .wr_i      (mem_wr),
      .rd_en_i   (rd_en),
      .rd_idx_i  (rd_idx),
      .rd_data_o (rd_data)
   );

endmodule

// ==== host_mem_rd.sv ====
// host memory read engine
// steps through a read burst and streams one beat per word
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module host_mem_rd
   import axi_pkg::*;
   import host_mem_pkg::*;
(
   input  logic                  clk_out,
   input  logic                  sync_rst_n,
   input  logic                  cmd_valid_i,
   output logic                  cmd_ready_o,
   input  axi_ax_t               cmd_i,
   output logic                  rvalid_o,
   input  logic                  rready_i,
   output axi_r_t                r_o,
   output logic                  rd_en_o,
   output mem_idx_t              rd_idx_o,
   input  logic [`HM_DATA_W-1:0] rd_data_i
);

   localparam int byte_off_w = $clog2(`HM_STRB_W);

   typedef enum logic [1:0] {
      st_idle,
      st_fetch,    // first word read
      st_stream
   } rd_state_t;

   rd_state_t            state;
   logic [`HM_ID_W-1:0]  id_q;
   logic [`HM_LEN_W-1:0] cnt_q;    // beats left after this one
   mem_idx_t             idx_q;    // next word to fetch
   logic                 cmd_take;
   logic                 beat_last;
   logic                 xfer;

   assign cmd_ready_o = (state == st_idle);
   assign rvalid_o    = (state == st_stream);
   assign cmd_take    = cmd_valid_i && cmd_ready_o;
   assign beat_last   = (cnt_q == '0);
   assign xfer        = rvalid_o && rready_i;

   // fetch ahead on each transfer, so the memory word holds while stalled
   assign rd_en_o  = (state == st_fetch) || (xfer && !beat_last);
   assign rd_idx_o = idx_q;

   always_comb begin
      r_o.id   = id_q;
      r_o.data = rd_data_i;
      r_o.resp = resp_okay;
      r_o.last = beat_last;
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:   if (cmd_take)          state <= st_fetch;
            st_fetch:                         state <= st_stream;
            st_stream: if (xfer && beat_last) state <= st_idle;
            default:                          state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (cmd_take) begin
         id_q  <= cmd_i.id;
         cnt_q <= cmd_i.len;
         idx_q <= cmd_i.addr[byte_off_w +: `HM_IDX_W];
      end else begin
         if (rd_en_o) idx_q <= idx_q + 1'b1;
         if (xfer && !beat_last) cnt_q <= cnt_q - 1'b1;
      end
   end

endmodule

// ==== host_mem_wr.sv ====
// host memory write engine
// takes a write command, stores its beats and returns one response
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module host_mem_wr
   import axi_pkg::*;
   import host_mem_pkg::*;
(
   input  logic    clk_out,
   input  logic    sync_rst_n,
   input  logic    cmd_valid_i,
   output logic    cmd_ready_o,
   input  axi_ax_t cmd_i,
   input  logic    wvalid_i,
   output logic    wready_o,
   input  axi_w_t  w_i,
   output logic    bvalid_o,
   input  logic    bready_i,
   output axi_b_t  b_o,
   output mem_wr_t mem_wr_o
);

   localparam int byte_off_w = $clog2(`HM_STRB_W);

   typedef enum logic [1:0] {
      st_idle,
      st_data,
      st_resp
   } wr_state_t;

   wr_state_t           state;
   logic [`HM_ID_W-1:0] id_q;
   mem_idx_t            idx_q;
   logic                cmd_take;
   logic                beat_take;
   logic                resp_done;

   assign cmd_ready_o = (state == st_idle);
   assign wready_o    = (state == st_data);
   assign bvalid_o    = (state == st_resp);

   assign cmd_take  = cmd_valid_i && cmd_ready_o;
   assign beat_take = wvalid_i && wready_o;
   assign resp_done = bvalid_o && bready_i;

   // --------------------
   // beat to memory write on the accepting edge
   always_comb begin
      mem_wr_o.en   = beat_take;
      mem_wr_o.idx  = idx_q;
      mem_wr_o.data = w_i.data;
      mem_wr_o.be   = w_i.strb;
      b_o.id        = id_q;
      b_o.resp      = resp_okay;
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: if (cmd_take)              state <= st_data;
            st_data: if (beat_take && w_i.last) state <= st_resp;
            st_resp: if (resp_done)             state <= st_idle;
            default:                            state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk_out) begin
      if (cmd_take) begin
         id_q  <= cmd_i.id;
         idx_q <= cmd_i.addr[byte_off_w +: `HM_IDX_W];   // word index wraps
      end else if (beat_take) begin
         idx_q <= idx_q + 1'b1;
      end
   end

endmodule

// ==== host_mem_array.sv ====
// host memory array
// word storage with byte write enables and a registered read port
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module host_mem_array
   import host_mem_pkg::*;
(
   input  logic                  clk_out,
   input  mem_wr_t               wr_i,
   input  logic                  rd_en_i,
   input  mem_idx_t              rd_idx_i,
   output logic [`HM_DATA_W-1:0] rd_data_o
);

   logic [`HM_DATA_W-1:0] mem [`HM_DEPTH];

   // one write lane per strobe bit
   always_ff @(posedge clk_out) begin
      for (int b = 0; b < `HM_STRB_W; b++) begin
         if (wr_i.en && wr_i.be[b]) begin
            mem[wr_i.idx][b*8 +: 8] <= wr_i.data[b*8 +: 8];
         end
      end
   end

   // read port holds its word while rd_en_i is low
   always_ff @(posedge clk_out) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_idx_i];   // old word on a same-cycle write
      end
   end

endmodule

// ==== cmd_fifo.sv ====
// command queue
// circular buffer with valid/ready on both sides and a typed payload
`timescale 1ns/1ps
`include "host_mem_consts.svh"

module cmd_fifo #(
   parameter type payload_t = logic
) (
   input  logic     clk_out,
   input  logic     sync_rst_n,
   input  logic     in_valid_i,
   output logic     in_ready_o,
   input  payload_t in_data_i,
   output logic     out_valid_o,
   input  logic     out_ready_i,
   output payload_t out_data_o
);

   localparam int ptr_w = $clog2(`HM_CMD_DEPTH);

   payload_t         entries [`HM_CMD_DEPTH];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [ptr_w:0]   count;
   logic             push;
   logic             pop;

   assign in_ready_o  = (count < `HM_CMD_DEPTH);
   assign out_valid_o = (count != '0);
   assign out_data_o  = entries[rd_ptr];   // head

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk_out) begin
      if (push) begin
         entries[wr_ptr] <= in_data_i;
      end
   end

   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== host_mem_pkg.sv ====
// host memory types
// word index and the byte-enabled write request
`include "host_mem_consts.svh"

package host_mem_pkg;

   typedef logic [`HM_IDX_W-1:0] mem_idx_t;

   // one word write where be selects the bytes
   typedef struct packed {
      logic                  en;
      mem_idx_t              idx;
      logic [`HM_DATA_W-1:0] data;
      logic [`HM_STRB_W-1:0] be;
   } mem_wr_t;

endpackage

// ==== axi_pkg.sv ====
// AXI channel payloads for the host memory slave
// one packed struct per channel and the okay response code
`include "host_mem_consts.svh"

package axi_pkg;

   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t resp_okay = 2'b00;

   // --------------------
   // address channels shared by aw and ar
   typedef struct packed {
      logic [`HM_ID_W-1:0]   id;
      logic [`HM_ADDR_W-1:0] addr;   // byte address
      logic [`HM_LEN_W-1:0]  len;
   } axi_ax_t;

   // --------------------
   // data and response channels
   typedef struct packed {
      logic [`HM_DATA_W-1:0] data;
      logic [`HM_STRB_W-1:0] strb;
      logic                  last;
   } axi_w_t;

   typedef struct packed {
      logic [`HM_ID_W-1:0] id;
      axi_resp_t           resp;
   } axi_b_t;

   typedef struct packed {
      logic [`HM_ID_W-1:0]   id;
      logic [`HM_DATA_W-1:0] data;
      axi_resp_t             resp;
      logic                  last;
   } axi_r_t;

endpackage

// ==== host_mem_consts.svh ====
// host memory constants
// bus widths, memory size and command queue depth
`ifndef HOST_MEM_CONSTS_SVH
`define HOST_MEM_CONSTS_SVH

// bus fields
`define HM_ADDR_W      16
`define HM_DATA_W      64
`define HM_STRB_W      8
`define HM_ID_W        5
`define HM_LEN_W       8      // beats minus one

// on-chip memory
`define HM_DEPTH       256
`define HM_IDX_W       8

`define HM_CMD_DEPTH   4      // per command queue

`endif
